//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ddr_memory_controller
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/ddr_bank_tracker.sv
`timescale 1ns/1ps

module ddr_bank_tracker (
  input  logic                               clk_n,
  input  logic                               rst_n,
  input  logic                               refresh_strobe,
  input  logic [ddr_ctrl_pkg::addr_w-1:0]    rand_req_address,
  input  logic                               rand_req_we,
  input  logic [ddr_ctrl_pkg::be_w-1:0]      rand_req_we_array,
  input  logic                               rand_req,
  output logic                               rand_req_ack,
  input  logic [ddr_ctrl_pkg::addr_w-1:0]    bulk_req_address,
  input  logic                               bulk_req_we,
  input  logic [ddr_ctrl_pkg::be_w-1:0]      bulk_req_we_array,
  input  logic                               bulk_req,
  input  logic                               bulk_req_algn,
  output logic                               bulk_req_ack,
  output logic                               bulk_req_algn_ack,
  output ddr_ctrl_pkg::mem_cmd_t             user_cmd,
  output ddr_ctrl_pkg::beat_ctl_t            beat_ctl
);

  ddr_ctrl_pkg::track_state_e          state;
  logic [3:0]                          cnt;
  logic [ddr_ctrl_pkg::n_bank-1:0]     open_flag;
  logic [ddr_ctrl_pkg::row_w-1:0]      open_row [ddr_ctrl_pkg::n_bank];
  logic                                refresh_pend;
  logic                                sel_bulk;
  logic                                sel_valid;
  logic                                sel_we;
  logic [ddr_ctrl_pkg::be_w-1:0]       sel_we_array;
  ddr_ctrl_pkg::user_addr_t            sel_addr;
  logic                                row_hit;
  logic                                row_load;
  logic                                req_bulk;
  logic                                req_we;
  logic [ddr_ctrl_pkg::be_w-1:0]       req_we_array;
  ddr_ctrl_pkg::user_addr_t            req_addr;
  logic [ddr_ctrl_pkg::n_bank-1:0]     act_issued;

  function automatic ddr_ctrl_pkg::mem_cmd_t access_cmd(input logic we,
                                                        input ddr_ctrl_pkg::user_addr_t a);
    access_cmd.cmd  = we ? ddr_ctrl_pkg::cmd_write : ddr_ctrl_pkg::cmd_read;
    access_cmd.bank = a.bank;
    access_cmd.addr = {{(ddr_ctrl_pkg::row_w - ddr_ctrl_pkg::col_w){1'b0}}, a.col};
  endfunction

  function automatic ddr_ctrl_pkg::beat_ctl_t start_beat(input logic we, input logic bulk,
                                                         input logic [3:0] wa);
    start_beat.wr_start  = we;
    start_beat.rd_start  = !we;
    start_beat.port_bulk = bulk;
    start_beat.we_array  = wa;
  endfunction

  // bulk wins while the align lock is held, random otherwise
  assign sel_bulk     = bulk_req && (bulk_req_algn_ack || !rand_req);
  assign sel_valid    = rand_req || bulk_req;
  assign sel_addr     = sel_bulk ? bulk_req_address : rand_req_address;
  assign sel_we       = sel_bulk ? bulk_req_we : rand_req_we;
  assign sel_we_array = sel_bulk ? bulk_req_we_array : rand_req_we_array;
  assign row_hit      = open_flag[sel_addr.bank] && open_row[sel_addr.bank] == sel_addr.row;
  assign row_load     = state == ddr_ctrl_pkg::st_idle && !refresh_pend && sel_valid &&
                        !open_flag[sel_addr.bank];

  always_ff @(posedge clk_n) begin
    if (row_load) open_row[sel_addr.bank] <= sel_addr.row;
    if (state == ddr_ctrl_pkg::st_idle) begin
      req_bulk     <= sel_bulk;
      req_we       <= sel_we;
      req_we_array <= sel_we_array;
      req_addr     <= sel_addr;
    end
  end

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      state             <= ddr_ctrl_pkg::st_idle;
      cnt               <= '0;
      open_flag         <= '0;
      refresh_pend      <= 1'b0;
      rand_req_ack      <= 1'b0;
      bulk_req_ack      <= 1'b0;
      bulk_req_algn_ack <= 1'b0;
      user_cmd          <= ddr_ctrl_pkg::nop_cmd;
      beat_ctl          <= '0;
    end else begin
      user_cmd     <= ddr_ctrl_pkg::nop_cmd;
      beat_ctl     <= '0;
      rand_req_ack <= 1'b0;
      bulk_req_ack <= 1'b0;
      if (refresh_strobe) refresh_pend <= 1'b1;
      if (!bulk_req_algn) bulk_req_algn_ack <= 1'b0;
      else if (state == ddr_ctrl_pkg::st_idle) bulk_req_algn_ack <= 1'b1;

      case (state)
        ddr_ctrl_pkg::st_idle: begin
          if (refresh_pend) begin
            if (|open_flag) begin   // close everything first
              user_cmd  <= '{cmd: ddr_ctrl_pkg::cmd_precharge, bank: '0,
                             addr: ddr_ctrl_pkg::pre_all_addr};
              open_flag <= '0;
              cnt       <= 4'(ddr_ctrl_pkg::t_rp - 2);   // idle adds one cycle
              state     <= ddr_ctrl_pkg::st_precharge;
            end else begin
              user_cmd     <= '{cmd: ddr_ctrl_pkg::cmd_auto_refresh, bank: '0, addr: '0};
              refresh_pend <= refresh_strobe;
              cnt          <= 4'(ddr_ctrl_pkg::t_rfc - 2);
              state        <= ddr_ctrl_pkg::st_refresh;
            end
          end else if (sel_valid) begin
            if (row_hit) begin
              user_cmd     <= access_cmd(sel_we, sel_addr);
              beat_ctl     <= start_beat(sel_we, sel_bulk, sel_we_array);
              rand_req_ack <= !sel_bulk;
              bulk_req_ack <= sel_bulk;
              state        <= ddr_ctrl_pkg::st_access;
            end else if (open_flag[sel_addr.bank]) begin   // wrong row open
              user_cmd <= '{cmd: ddr_ctrl_pkg::cmd_precharge, bank: sel_addr.bank, addr: '0};
              open_flag[sel_addr.bank] <= 1'b0;
              cnt      <= 4'(ddr_ctrl_pkg::t_rp - 2);
              state    <= ddr_ctrl_pkg::st_precharge;
            end else begin
              user_cmd <= '{cmd: ddr_ctrl_pkg::cmd_active, bank: sel_addr.bank,
                            addr: sel_addr.row};
              open_flag[sel_addr.bank] <= 1'b1;
              cnt      <= 4'(ddr_ctrl_pkg::t_rcd - 1);
              state    <= ddr_ctrl_pkg::st_activate;
            end
          end
        end
        ddr_ctrl_pkg::st_precharge, ddr_ctrl_pkg::st_refresh, ddr_ctrl_pkg::st_recover: begin
          if (cnt == '0) state <= ddr_ctrl_pkg::st_idle;
          else cnt <= cnt - 4'd1;
        end
        ddr_ctrl_pkg::st_activate: begin
          if (cnt != '0) begin
            cnt <= cnt - 4'd1;
          end else begin
            user_cmd     <= access_cmd(req_we, req_addr);
            beat_ctl     <= start_beat(req_we, req_bulk, req_we_array);
            rand_req_ack <= !req_bulk;
            bulk_req_ack <= req_bulk;
            state        <= ddr_ctrl_pkg::st_access;
          end
        end
        ddr_ctrl_pkg::st_access: begin
          cnt   <= req_we ? 4'(ddr_ctrl_pkg::t_wr) : 4'd0;   // write recovery
          state <= ddr_ctrl_pkg::st_recover;
        end
        default: state <= ddr_ctrl_pkg::st_idle;
      endcase
    end
  end

  // banks activated since their last precharge, seen from the issued commands only
  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      act_issued <= '0;
    end else if (user_cmd.cmd == ddr_ctrl_pkg::cmd_precharge) begin
      if (user_cmd.addr[10]) act_issued <= '0;   // precharge all
      else act_issued[user_cmd.bank] <= 1'b0;
    end else if (user_cmd.cmd == ddr_ctrl_pkg::cmd_active) begin
      act_issued[user_cmd.bank] <= 1'b1;
    end
  end

  a_one_ack: assert property (@(posedge clk_n) disable iff (!rst_n)
    !(rand_req_ack && bulk_req_ack));

  a_ack_in_access: assert property (@(posedge clk_n) disable iff (!rst_n)
    (rand_req_ack || bulk_req_ack) |-> state == ddr_ctrl_pkg::st_access);

  // an activate needs a precharge of its bank since the last activate there
  a_act_closed: assert property (@(posedge clk_n) disable iff (!rst_n)
    user_cmd.cmd == ddr_ctrl_pkg::cmd_active |-> !act_issued[user_cmd.bank]);

endmodule

//--- hdl/ddr_ctrl_pkg.sv
package ddr_ctrl_pkg;

  localparam int addr_w = 26;
  localparam int row_w = 13;
  localparam int col_w = 10;
  localparam int bank_w = 2;
  localparam int n_bank = 1 << bank_w;
  localparam int dq_w = 16;
  localparam int word_w = 2 * dq_w;
  localparam int be_w = word_w / 8;

  localparam int t_rp = 2;
  localparam int t_rcd = 2;
  localparam int t_rfc = 6;
  localparam int t_wr = 2;
  localparam int t_mrd = 2;
  localparam int cas_lat = 2;   // tracker read cmd to first beat on dq
  localparam int init_wait = 16;

  // burst length 2 in a[2:0], cas latency 2 in a[6:4]
  localparam logic [row_w-1:0] mode_word = 13'h0021;
  localparam logic [row_w-1:0] pre_all_addr = 13'h0400;   // a10 selects all banks

  // ras_n, cas_n, we_n as seen on the pins
  typedef enum logic [2:0] {
    cmd_load_mode    = 3'b000,
    cmd_auto_refresh = 3'b001,
    cmd_precharge    = 3'b010,
    cmd_active       = 3'b011,
    cmd_write        = 3'b100,
    cmd_read         = 3'b101,
    cmd_burst_stop   = 3'b110,
    cmd_nop          = 3'b111
  } mem_cmd_e;

  typedef enum logic [2:0] {
    st_idle,
    st_refresh,
    st_precharge,
    st_activate,
    st_access,
    st_recover
  } track_state_e;

  typedef struct packed {
    mem_cmd_e               cmd;
    logic [bank_w-1:0]      bank;
    logic [row_w-1:0]       addr;
  } mem_cmd_t;

  typedef struct packed {
    logic                   wr_start;
    logic                   rd_start;
    logic                   port_bulk;
    logic [be_w-1:0]        we_array;
  } beat_ctl_t;

  // user word address, lsb dropped since words are 32-bit aligned
  typedef struct packed {
    logic [bank_w-1:0]      bank;
    logic [row_w-1:0]       row;
    logic [col_w-1:0]       col;
    logic                   lsb;
  } user_addr_t;

  localparam mem_cmd_t nop_cmd = '{cmd: cmd_nop, bank: '0, addr: '0};

endpackage

//--- hdl/ddr_data_path.sv
`timescale 1ns/1ps

module ddr_data_path (
  input  logic                               clk_n,
  input  logic                               rst_n,
  input  ddr_ctrl_pkg::beat_ctl_t            beat_ctl,
  input  logic [ddr_ctrl_pkg::word_w-1:0]    rand_req_datain,
  input  logic [ddr_ctrl_pkg::word_w-1:0]    bulk_req_datain,
  inout  wire  [ddr_ctrl_pkg::dq_w-1:0]      dq,
  inout  wire                                dqs,
  output logic                               dm,
  output logic [ddr_ctrl_pkg::word_w-1:0]    user_req_dataout,
  output logic                               rd_valid
);

  logic [2:0]                          wr_sh;   // [1] low beat, [2] high beat
  logic [ddr_ctrl_pkg::cas_lat:0]      rd_sh;
  logic [ddr_ctrl_pkg::word_w-1:0]     wr_word;
  logic [ddr_ctrl_pkg::be_w-1:0]       wr_be;
  logic [ddr_ctrl_pkg::dq_w-1:0]       rd_lo;
  logic [ddr_ctrl_pkg::dq_w-1:0]       dq_out;
  logic [1:0]                          beat_be;
  logic                                dq_oe;

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      wr_sh    <= '0;
      rd_sh    <= '0;
      rd_valid <= 1'b0;
    end else begin
      wr_sh    <= {wr_sh[1:0], beat_ctl.wr_start};
      rd_sh    <= {rd_sh[ddr_ctrl_pkg::cas_lat-1:0], beat_ctl.rd_start};
      rd_valid <= rd_sh[ddr_ctrl_pkg::cas_lat];
    end
  end

  always_ff @(posedge clk_n) begin
    if (beat_ctl.wr_start) begin   // port data is still held in the ack cycle
      wr_word <= beat_ctl.port_bulk ? bulk_req_datain : rand_req_datain;
      wr_be   <= beat_ctl.we_array;
    end
    if (rd_sh[ddr_ctrl_pkg::cas_lat-1]) rd_lo <= dq;
    if (rd_sh[ddr_ctrl_pkg::cas_lat]) user_req_dataout <= {dq, rd_lo};
  end

  assign dq_oe   = wr_sh[1] | wr_sh[2];
  assign dq_out  = wr_sh[1] ? wr_word[15:0] : wr_word[31:16];
  assign beat_be = wr_sh[1] ? wr_be[1:0] : wr_be[3:2];
  // dm masks the whole beat, so a beat lands only when both its bytes are enabled
  assign dm      = dq_oe && !(&beat_be);
  assign dq      = dq_oe ? dq_out : 'z;
  assign dqs     = dq_oe ? wr_sh[1] : 1'bz;   // high on the low beat

  a_no_bus_clash: assert property (@(posedge clk_n) disable iff (!rst_n)
    !(dq_oe && (rd_sh[ddr_ctrl_pkg::cas_lat-1] || rd_sh[ddr_ctrl_pkg::cas_lat])));

endmodule

//--- hdl/ddr_initializer.sv
`timescale 1ns/1ps

module ddr_initializer (
  input  logic                               clk_n,
  input  logic                               rst_n,
  input  ddr_ctrl_pkg::mem_cmd_t             user_cmd,
  output logic                               cke,
  output logic [2:0]                         command,
  output logic [ddr_ctrl_pkg::row_w-1:0]     address,
  output logic [ddr_ctrl_pkg::bank_w-1:0]    bank,
  output logic                               rst_user
);

  typedef enum logic [2:0] {
    init_cke,
    init_wait,
    init_pre,
    init_ref1,
    init_ref2,
    init_mode,
    init_done
  } init_state_e;

  init_state_e            state;
  logic [4:0]             cnt;
  ddr_ctrl_pkg::mem_cmd_t pin_cmd;

  always_ff @(posedge clk_n or negedge rst_n) begin
    if (!rst_n) begin
      state    <= init_cke;
      cnt      <= '0;
      cke      <= 1'b0;
      rst_user <= 1'b0;
      pin_cmd  <= ddr_ctrl_pkg::nop_cmd;
    end else begin
      pin_cmd <= ddr_ctrl_pkg::nop_cmd;   // commands last one cycle
      case (state)
        init_cke: begin
          cke   <= 1'b1;
          cnt   <= 5'(ddr_ctrl_pkg::init_wait - 1);
          state <= init_wait;
        end
        init_wait: begin
          if (cnt != '0) begin
            cnt <= cnt - 5'd1;
          end else begin
            pin_cmd <= '{cmd: ddr_ctrl_pkg::cmd_precharge, bank: '0,
                         addr: ddr_ctrl_pkg::pre_all_addr};
            cnt     <= 5'(ddr_ctrl_pkg::t_rp - 1);
            state   <= init_pre;
          end
        end
        init_pre, init_ref1: begin
          if (cnt != '0) begin
            cnt <= cnt - 5'd1;
          end else begin
            pin_cmd <= '{cmd: ddr_ctrl_pkg::cmd_auto_refresh, bank: '0, addr: '0};
            cnt     <= 5'(ddr_ctrl_pkg::t_rfc - 1);
            state   <= (state == init_pre) ? init_ref1 : init_ref2;
          end
        end
        init_ref2: begin
          if (cnt != '0) begin
            cnt <= cnt - 5'd1;
          end else begin
            pin_cmd <= '{cmd: ddr_ctrl_pkg::cmd_load_mode, bank: '0,
                         addr: ddr_ctrl_pkg::mode_word};
            cnt     <= 5'(ddr_ctrl_pkg::t_mrd - 1);
            state   <= init_mode;
          end
        end
        init_mode: begin
          if (cnt != '0) begin
            cnt <= cnt - 5'd1;
          end else begin
            rst_user <= 1'b1;   // tracker leaves reset here
            state    <= init_done;
          end
        end
        init_done: pin_cmd <= user_cmd;   // one register stage to the pins
        default: state <= init_cke;
      endcase
    end
  end

  assign command = pin_cmd.cmd;
  assign address = pin_cmd.addr;
  assign bank    = pin_cmd.bank;

  // the memory ignores commands until the clock is enabled
  a_nop_before_cke: assert property (@(posedge clk_n) disable iff (!rst_n)
    !cke |-> pin_cmd.cmd == ddr_ctrl_pkg::cmd_nop);

endmodule

//--- hdl/ddr_memory_controller.sv
`timescale 1ns/1ps

module ddr_memory_controller (
  input  logic                               clk_n,
  input  logic                               rst_n,
  input  logic                               refresh_strobe,
  input  logic [ddr_ctrl_pkg::addr_w-1:0]    rand_req_address,
  input  logic                               rand_req_we,
  input  logic [ddr_ctrl_pkg::be_w-1:0]      rand_req_we_array,
  input  logic                               rand_req,
  output logic                               rand_req_ack,
  input  logic [ddr_ctrl_pkg::word_w-1:0]    rand_req_datain,
  input  logic [ddr_ctrl_pkg::addr_w-1:0]    bulk_req_address,
  input  logic                               bulk_req_we,
  input  logic [ddr_ctrl_pkg::be_w-1:0]      bulk_req_we_array,
  input  logic                               bulk_req,
  output logic                               bulk_req_ack,
  input  logic                               bulk_req_algn,
  output logic                               bulk_req_algn_ack,
  input  logic [ddr_ctrl_pkg::word_w-1:0]    bulk_req_datain,
  output logic [ddr_ctrl_pkg::word_w-1:0]    user_req_dataout,
  output logic                               rd_valid,
  output logic                               cke,
  output logic [2:0]                         command,
  output logic [ddr_ctrl_pkg::row_w-1:0]     address,
  output logic [ddr_ctrl_pkg::bank_w-1:0]    bank,
  inout  wire  [ddr_ctrl_pkg::dq_w-1:0]      dq,
  inout  wire                                dqs,
  output logic                               dm
);

  ddr_ctrl_pkg::mem_cmd_t  user_cmd;
  ddr_ctrl_pkg::beat_ctl_t beat_ctl;
  logic                    rst_user;   // holds the tracker until init is done

  ddr_initializer ddr_initializer_inst (
    .clk_n    (clk_n),
    .rst_n    (rst_n),
    .user_cmd (user_cmd),
    .cke      (cke),
    .command  (command),
    .address  (address),
    .bank     (bank),
    .rst_user (rst_user)
  );

  ddr_bank_tracker ddr_bank_tracker_inst (
    .clk_n             (clk_n),
    .rst_n             (rst_user),
    .refresh_strobe    (refresh_strobe),
    .rand_req_address  (rand_req_address),
    .rand_req_we       (rand_req_we),
    .rand_req_we_array (rand_req_we_array),
    .rand_req          (rand_req),
    .rand_req_ack      (rand_req_ack),
    .bulk_req_address  (bulk_req_address),
    .bulk_req_we       (bulk_req_we),
    .bulk_req_we_array (bulk_req_we_array),
    .bulk_req          (bulk_req),
    .bulk_req_algn     (bulk_req_algn),
    .bulk_req_ack      (bulk_req_ack),
    .bulk_req_algn_ack (bulk_req_algn_ack),
    .user_cmd          (user_cmd),
    .beat_ctl          (beat_ctl)
  );

  ddr_data_path ddr_data_path_inst (
    .clk_n            (clk_n),
    .rst_n            (rst_n),
    .beat_ctl         (beat_ctl),
    .rand_req_datain  (rand_req_datain),
    .bulk_req_datain  (bulk_req_datain),
    .dq               (dq),
    .dqs              (dqs),
    .dm               (dm),
    .user_req_dataout (user_req_dataout),
    .rd_valid         (rd_valid)
  );

endmodule

//--- sim.f
hdl/ddr_ctrl_pkg.sv
hdl/ddr_initializer.sv
hdl/ddr_bank_tracker.sv
hdl/ddr_data_path.sv
hdl/ddr_memory_controller.sv
tests/ddr_sdram_model.sv
tests/tb_ddr_memory_controller.sv

//--- tests/ddr_sdram_model.sv
`timescale 1ns/1ps

module ddr_sdram_model (
  input  logic                               clk_n,
  input  logic                               cke,
  input  logic [2:0]                         command,
  input  logic [ddr_ctrl_pkg::row_w-1:0]     address,
  input  logic [ddr_ctrl_pkg::bank_w-1:0]    bank,
  inout  wire  [ddr_ctrl_pkg::dq_w-1:0]      dq,
  inout  wire                                dqs,
  input  logic                               dm
);

  logic [ddr_ctrl_pkg::dq_w-1:0]   mem [int unsigned];   // key is {bank, row, col, beat}
  logic [ddr_ctrl_pkg::row_w-1:0]  row_of [ddr_ctrl_pkg::n_bank];
  logic [24:0]                     wr_base;
  logic [1:0]                      wr_ph = 2'd0;   // 01 low beat next, 10 high beat next
  logic [24:0]                     rd_base;
  logic                            rd_hi = 1'b0;
  logic                            rd_oe = 1'b0;
  logic [ddr_ctrl_pkg::dq_w-1:0]   rd_beat;

  function automatic logic [15:0] fetch(input logic [25:0] key);
    if (mem.exists(32'(key))) return mem[32'(key)];
    return key[15:0] ^ {6'd0, key[25:16]};   // beats never written
  endfunction

  always @(posedge clk_n) begin
    if (wr_ph != 2'd0) begin
      if (!dm) mem[32'({wr_base, wr_ph[1]})] = dq;   // dm drops the whole beat
      wr_ph <= {wr_ph[0], 1'b0};
    end
    rd_oe <= rd_hi;
    rd_hi <= 1'b0;
    if (rd_hi) rd_beat <= fetch({rd_base, 1'b1});
    if (cke) begin
      case (command)
        ddr_ctrl_pkg::cmd_active: row_of[bank] <= address;
        ddr_ctrl_pkg::cmd_write: begin
          wr_base <= {bank, row_of[bank], address[ddr_ctrl_pkg::col_w-1:0]};
          wr_ph   <= 2'd1;
        end
        ddr_ctrl_pkg::cmd_read: begin
          // controller counts cas latency from its own command register
          rd_base <= {bank, row_of[bank], address[ddr_ctrl_pkg::col_w-1:0]};
          rd_beat <= fetch({bank, row_of[bank], address[ddr_ctrl_pkg::col_w-1:0], 1'b0});
          rd_oe   <= 1'b1;
          rd_hi   <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign dq  = rd_oe ? rd_beat : 'z;
  assign dqs = rd_oe ? rd_hi : 1'bz;   // high on the low beat

endmodule

//--- tests/ddr_stim.txt
# port: 0 random, 1 bulk, 2 random racing the bulk op on the next line, 3 refresh pulse
# port we algn address we_array data expected_read (all hex, expected used on reads)
0 1 0 0008008 f 11223344 00000000
0 0 0 0008008 0 00000000 11223344
0 1 0 0008008 c aabbccdd 00000000
0 0 0 0008008 0 00000000 aabb3344
0 1 0 0008008 7 55667788 00000000
0 0 0 0008008 0 00000000 aabb7788
2 1 0 0011008 f 01010101 00000000
1 1 0 1008008 f 02020202 00000000
0 0 0 0011008 0 00000000 01010101
1 0 0 1008008 0 00000000 02020202
2 1 1 200287e f 03030303 00000000
1 1 1 3fffffe f 04040404 00000000
1 0 1 3fffffe 0 00000000 04040404
0 0 0 200287e 0 00000000 03030303
3 0 0 0000000 0 00000000 00000000
0 0 0 0008008 0 00000000 aabb7788
1 0 0 1008008 0 00000000 02020202
0 1 0 0011008 3 ffffeeee 00000000
0 0 0 0011008 0 00000000 0101eeee
1 0 0 3fffffe 0 00000000 04040404

//--- tests/tb_ddr_memory_controller.sv
`timescale 1ns/1ps

module tb_ddr_memory_controller;

  typedef struct packed {
    logic [1:0]  port;   // 0 random, 1 bulk, 2 race with next line, 3 refresh
    logic        we;
    logic        algn;
    logic [25:0] addr;
    logic [3:0]  we_array;
    logic [31:0] data;
    logic [31:0] rd_exp;
  } stim_op_t;

  localparam int rst_cycles = 4;
  localparam int op_cycles = 64;
  localparam int init_cycles = 2 * ddr_ctrl_pkg::init_wait;

  logic        clk_n = 1'b0;
  logic        rst_n;
  logic        refresh_strobe;
  logic [25:0] rand_req_address;
  logic        rand_req_we;
  logic [3:0]  rand_req_we_array;
  logic        rand_req;
  logic        rand_req_ack;
  logic [31:0] rand_req_datain;
  logic [25:0] bulk_req_address;
  logic        bulk_req_we;
  logic [3:0]  bulk_req_we_array;
  logic        bulk_req;
  logic        bulk_req_ack;
  logic        bulk_req_algn;
  logic        bulk_req_algn_ack;
  logic [31:0] bulk_req_datain;
  logic [31:0] user_req_dataout;
  logic        rd_valid;
  logic        cke;
  logic [2:0]  command;
  logic [12:0] address;
  logic [1:0]  bank;
  wire  [15:0] dq;
  wire         dqs;
  logic        dm;

  stim_op_t    ops[$];
  int          n_ops = 0;
  int          errors = 0;
  logic [2:0]  init_cmds[$];
  logic        acked_once = 1'b0;
  int          refresh_count = 0;
  logic [1:0]  wr_beat = 2'b00;   // write beats due on dq, low then high
  logic        dqs_lo;

  always #4 clk_n = ~clk_n;

  ddr_memory_controller ddr_memory_controller_inst (.*);

  ddr_sdram_model ddr_sdram_model_inst (
    .clk_n   (clk_n),
    .cke     (cke),
    .command (command),
    .address (address),
    .bank    (bank),
    .dq      (dq),
    .dqs     (dqs),
    .dm      (dm)
  );

  // pin commands up to the first ack, and a running count of auto refreshes
  always @(negedge clk_n) begin
    if (rst_n && !acked_once) begin
      if (command != ddr_ctrl_pkg::cmd_nop) init_cmds.push_back(command);
      if (rand_req_ack || bulk_req_ack) acked_once <= 1'b1;
    end
    if (command == ddr_ctrl_pkg::cmd_auto_refresh) refresh_count <= refresh_count + 1;
  end

  // dqs has to toggle between the two write beats that follow a write command
  always @(negedge clk_n) begin
    wr_beat <= {wr_beat[0], command == ddr_ctrl_pkg::cmd_write};
    if (wr_beat[0]) dqs_lo <= dqs;
    if (wr_beat[1]) check_value("dqs on high write beat", 32'(dqs), 32'(!dqs_lo));
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic step();
    @(posedge clk_n);
    #1;
  endtask

  task automatic drive_port(input logic bulk, input stim_op_t op);
    if (bulk) begin
      bulk_req_address  = op.addr;
      bulk_req_we       = op.we;
      bulk_req_we_array = op.we_array;
      bulk_req_datain   = op.data;
      bulk_req          = 1'b1;
    end else begin
      rand_req_address  = op.addr;
      rand_req_we       = op.we;
      rand_req_we_array = op.we_array;
      rand_req_datain   = op.data;
      rand_req          = 1'b1;
    end
  endtask

  // each req drops in the cycle after its ack
  task automatic wait_acks(input logic want_rand, input logic want_bulk,
                           output logic bulk_first);
    logic got_rand;
    logic got_bulk;
    got_rand   = !want_rand;
    got_bulk   = !want_bulk;
    bulk_first = 1'b0;
    while (!(got_rand && got_bulk)) begin
      @(negedge clk_n);
      if (bulk_req_ack && !got_rand) bulk_first = 1'b1;
      got_rand = got_rand || rand_req_ack;
      got_bulk = got_bulk || bulk_req_ack;
      step();
      if (got_rand) rand_req = 1'b0;
      if (got_bulk) bulk_req = 1'b0;
    end
  endtask

  task automatic wait_read(input logic [31:0] expected, input logic [25:0] addr);
    do @(negedge clk_n); while (!rd_valid);
    check_value($sformatf("user_req_dataout at %h", addr), user_req_dataout, expected);
  endtask

  task automatic set_align(input logic algn);
    if (algn && !bulk_req_algn) begin
      bulk_req_algn = 1'b1;
      do @(negedge clk_n); while (!bulk_req_algn_ack);
      step();
    end else if (!algn && bulk_req_algn) begin
      bulk_req_algn = 1'b0;
      step();
    end
  endtask

  task automatic pulse_refresh();
    repeat ($urandom_range(3, 0)) step();
    refresh_strobe = 1'b1;
    step();
    refresh_strobe = 1'b0;
  endtask

  task automatic check_init_sequence();
    logic [2:0] seq [4];
    seq[0] = ddr_ctrl_pkg::cmd_precharge;
    seq[1] = ddr_ctrl_pkg::cmd_auto_refresh;
    seq[2] = ddr_ctrl_pkg::cmd_auto_refresh;
    seq[3] = ddr_ctrl_pkg::cmd_load_mode;
    check_value("init command count ok", 32'(init_cmds.size() >= 4), 32'd1);
    if (init_cmds.size() >= 4) begin
      for (int i = 0; i < 4; i++) begin
        check_value($sformatf("init command %0d", i), 32'(init_cmds[i]), 32'(seq[i]));
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          idx;
    int          refresh_mark;
    logic        refresh_armed;
    logic        init_checked;
    logic        bulk_first;
    string       line;
    stim_op_t    op;
    logic [31:0] f_port, f_we, f_algn, f_addr, f_be, f_data, f_exp;

    rst_n             = 1'b0;
    refresh_strobe    = 1'b0;
    rand_req          = 1'b0;
    rand_req_address  = '0;
    rand_req_we       = 1'b0;
    rand_req_we_array = '0;
    rand_req_datain   = '0;
    bulk_req          = 1'b0;
    bulk_req_address  = '0;
    bulk_req_we       = 1'b0;
    bulk_req_we_array = '0;
    bulk_req_datain   = '0;
    bulk_req_algn     = 1'b0;
    refresh_armed     = 1'b0;
    refresh_mark      = 0;
    init_checked      = 1'b0;
    void'($urandom(32'he3ad));

    fd = $fopen("tests/ddr_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/ddr_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      f_port, f_we, f_algn, f_addr, f_be, f_data, f_exp);
          if (n == 7) begin
            op.port     = f_port[1:0];
            op.we       = f_we[0];
            op.algn     = f_algn[0];
            op.addr     = f_addr[25:0];
            op.we_array = f_be[3:0];
            op.data     = f_data;
            op.rd_exp   = f_exp;
            ops.push_back(op);
          end
        end
      end
      $fclose(fd);
      if (ops.size() == 0) begin
        $display("the stim file holds no operations");
        errors++;
      end
    end
    n_ops = ops.size();

    repeat (rst_cycles) @(posedge clk_n);
    #1;
    rst_n = 1'b1;

    idx = 0;
    while (idx < n_ops) begin
      op = ops[idx];
      set_align(op.algn);
      if (op.port == 2'd3) begin
        refresh_mark  = refresh_count;
        refresh_armed = 1'b1;
        pulse_refresh();
      end else begin
        if (op.port == 2'd2 && idx + 1 < n_ops) begin
          drive_port(1'b0, op);   // both reqs rise in the same cycle
          drive_port(1'b1, ops[idx + 1]);
          wait_acks(1'b1, 1'b1, bulk_first);
          check_value("bulk_req_ack first", 32'(bulk_first), 32'(op.algn));
          idx++;
        end else begin
          drive_port(op.port[0], op);
          wait_acks(!op.port[0], op.port[0], bulk_first);
          if (!op.we) wait_read(op.rd_exp, op.addr);
        end
        if (refresh_armed) begin
          check_value("auto_refresh before ack", 32'(refresh_count > refresh_mark), 32'd1);
          refresh_armed = 1'b0;
        end
      end
      if (!init_checked && acked_once) begin
        check_init_sequence();
        init_checked = 1'b1;
      end
      repeat ($urandom_range(3, 0)) step();
      idx++;
    end

    repeat (4) step();
    $display("errors: %0d in %0d operations", errors, n_ops);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // budget grows with the number of operations in the stim file
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * op_cycles + init_cycles + rst_cycles) @(posedge clk_n);
    $display("run timed out before all %0d operations finished, %0d errors", n_ops, errors);
    $display("test failed");
    $finish;
  end

endmodule
